// ==== common/smg_pkg.sv ====
package smg_pkg;

    ////////////////////////////////////////////////////////////
    // Display geometry
    ////////////////////////////////////////////////////////////

    // Six digits, bit/index 5 is the leftmost
    localparam int NUM_DIGITS = 6;
    localparam int IDX_W      = $clog2(NUM_DIGITS);

    // Binary input and its display limit
    localparam int          VALUE_W   = 20;
    localparam int unsigned VALUE_MAX = 999999;

    // One BCD column
    localparam int BCD_W = 4;

    // Converter step counter, counts 0 .. VALUE_W-1
    localparam int STEP_W = $clog2(VALUE_W);

    // 1 ms per digit at 50 MHz
    localparam int DIGIT_CYCLES_DEF = 50000;

    ////////////////////////////////////////////////////////////
    // Shared types
    ////////////////////////////////////////////////////////////

    // Active-low digit select, bit 5 leftmost
    typedef logic [NUM_DIGITS-1:0] scan_t;

    // Active-low segments, [6:0] = g..a, [7] = decimal point
    typedef logic [7:0] seg_t;

    // Six BCD digits, index 5 leftmost
    typedef logic [NUM_DIGITS-1:0][BCD_W-1:0] bcd_digits_t;

    // Active digit position, 0 = leftmost
    typedef logic [IDX_W-1:0] digit_idx_t;

    // Idle levels for the outputs
    localparam scan_t SCAN_OFF = '1;
    localparam seg_t  SEG_OFF  = '1;

endpackage

// ==== src/bin_to_bcd.sv ====
module bin_to_bcd
    import smg_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load,
    input  logic [VALUE_W-1:0] value,
    output logic               busy,
    output bcd_digits_t        digits,
    output logic               digits_valid
);

    logic [VALUE_W-1:0] shift_q;
    logic [VALUE_W-1:0] shift_step;
    logic [VALUE_W-1:0] clamped;
    bcd_digits_t        acc_q;
    bcd_digits_t        acc_adj;
    bcd_digits_t        acc_step;
    logic [STEP_W-1:0]  step;
    logic               last_step;

    // Correct every column of 5 or more before the shift
    function automatic bcd_digits_t add3(input bcd_digits_t d);
        bcd_digits_t r;
        r = d;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            if (d[i] >= BCD_W'(5))
                r[i] = d[i] + BCD_W'(3);
        end
        return r;
    endfunction

    assign clamped   = (value > VALUE_MAX) ? VALUE_W'(VALUE_MAX) : value;
    assign acc_adj   = add3(acc_q);
    assign {acc_step, shift_step} = {acc_adj, shift_q} << 1;
    assign last_step = (step == STEP_W'(VALUE_W - 1));

    ////////////////////////////////////////////////////////////
    // Control, one step per cycle while busy
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy         <= 1'b0;
            step         <= '0;
            digits_valid <= 1'b0;
        end else begin
            digits_valid <= 1'b0;
            if (!busy) begin
                // Loads while busy never reach here
                if (load) begin
                    busy <= 1'b1;
                    step <= '0;
                end
            end else if (last_step) begin
                busy         <= 1'b0;
                digits_valid <= 1'b1;
            end else begin
                step <= step + 1'b1;
            end
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (!busy && load) begin
            shift_q <= clamped;
            acc_q   <= '0;
        end else if (busy) begin
            shift_q <= shift_step;
            acc_q   <= acc_step;
        end
    end

    // Publish on the final step
    always_ff @(posedge clk) begin
        if (busy && last_step)
            digits <= acc_step;
    end

    // Result only ever lands as busy drops
    assert property (@(posedge clk) disable iff (!rst_n)
        digits_valid |-> !busy && $past(busy));

endmodule

// ==== smg/digit_scan.sv ====
module digit_scan
    import smg_pkg::*;
#(
    parameter int DIGIT_CYCLES = DIGIT_CYCLES_DEF
) (
    input  logic       clk,
    input  logic       rst_n,
    output scan_t      scan_pre,
    output digit_idx_t scan_idx,
    output logic       frame_start
);

    typedef logic [$clog2(DIGIT_CYCLES)-1:0] cnt_t;

    logic       run;
    cnt_t       cnt;
    logic       wrap;
    digit_idx_t idx_next;

    // Dwell counter only runs once the first digit is selected
    assign wrap = run && (cnt == cnt_t'(DIGIT_CYCLES - 1));

    // Left to right, then back to the leftmost digit
    always_comb begin
        idx_next = scan_idx;
        if (wrap) begin
            if (scan_idx == digit_idx_t'(NUM_DIGITS - 1))
                idx_next = '0;
            else
                idx_next = scan_idx + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run         <= 1'b0;
            cnt         <= '0;
            scan_idx    <= '0;
            scan_pre    <= SCAN_OFF;
            frame_start <= 1'b0;
        end else begin
            run <= 1'b1;
            if (wrap)
                cnt <= '0;
            else if (run)
                cnt <= cnt + 1'b1;
            scan_idx    <= idx_next;
            // One select line low, index 0 drives bit 5
            scan_pre    <= ~(scan_t'(1) << (NUM_DIGITS - 1 - int'(idx_next)));
            frame_start <= !run || (wrap && scan_idx == digit_idx_t'(NUM_DIGITS - 1));
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        run |-> $onehot(~scan_pre));

    assert property (@(posedge clk) disable iff (!rst_n)
        scan_idx < NUM_DIGITS);

endmodule

// ==== smg/digit_select.sv ====
module digit_select
    import smg_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  bcd_digits_t           digits,
    input  logic                  digits_valid,
    input  logic                  frame_start,
    input  digit_idx_t            scan_idx,
    input  logic                  blank_en,
    input  logic [NUM_DIGITS-1:0] dp_mask,
    output logic [BCD_W-1:0]      bcd,
    output logic                  blank,
    output logic                  dp
);

    bcd_digits_t           pending;
    bcd_digits_t           shown;
    bcd_digits_t           frame_digits;
    logic [NUM_DIGITS-1:0] lead_zero;
    logic                  zero_run;
    digit_idx_t            digit_pos;

    ////////////////////////////////////////////////////////////
    // Pending and shown copies
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
            shown   <= '0;
        end else begin
            if (digits_valid)
                pending <= digits;
            // Swap only between frames
            if (frame_start)
                shown <= pending;
        end
    end

    // First cycle of a frame already uses the new copy
    assign frame_digits = frame_start ? pending : shown;

    ////////////////////////////////////////////////////////////
    // Active digit
    ////////////////////////////////////////////////////////////

    // lead_zero[p] set when positions 0..p are all zero
    always_comb begin
        lead_zero = '0;
        zero_run  = 1'b1;
        for (int p = 0; p < NUM_DIGITS; p++) begin
            zero_run     = zero_run && (frame_digits[NUM_DIGITS-1-p] == '0);
            lead_zero[p] = zero_run;
        end
    end

    // Scan position 0 maps to array index 5
    assign digit_pos = digit_idx_t'(NUM_DIGITS - 1) - scan_idx;

    assign bcd = frame_digits[digit_pos];

    // Rightmost digit always shows, so zero reads as 0
    assign blank = blank_en && lead_zero[scan_idx] &&
                   (scan_idx != digit_idx_t'(NUM_DIGITS - 1));

    assign dp = dp_mask[digit_pos];

endmodule

// ==== smg/seg_encode.sv ====
module seg_encode
    import smg_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic [BCD_W-1:0] bcd,
    input  logic             blank,
    input  logic             dp,
    input  scan_t            scan_pre,
    output seg_t             smg_data,
    output scan_t            scan_sig
);

    logic [6:0] seg7;

    ////////////////////////////////////////////////////////////
    // Decoder, active low, bit order g f e d c b a
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (bcd)
            4'd0:    seg7 = 7'b100_0000;
            4'd1:    seg7 = 7'b111_1001;
            4'd2:    seg7 = 7'b010_0100;
            4'd3:    seg7 = 7'b011_0000;
            4'd4:    seg7 = 7'b001_1001;
            4'd5:    seg7 = 7'b001_0010;
            4'd6:    seg7 = 7'b000_0010;
            4'd7:    seg7 = 7'b111_1000;
            4'd8:    seg7 = 7'b000_0000;
            4'd9:    seg7 = 7'b001_0000;
            default: seg7 = 7'b111_1111;
        endcase
        if (blank)
            seg7 = 7'b111_1111;
    end

    // Segments and digit select leave together
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            smg_data <= SEG_OFF;
            scan_sig <= SCAN_OFF;
        end else begin
            // Point stays independent of blanking
            smg_data <= {~dp, seg7};
            scan_sig <= scan_pre;
        end
    end

    // Converter and selector never hand over a non-decimal digit
    assert property (@(posedge clk) disable iff (!rst_n)
        !blank |-> bcd <= BCD_W'(9));

endmodule

// ==== src/smg_display.sv ====
module smg_display
    import smg_pkg::*;
#(
    parameter int DIGIT_CYCLES = DIGIT_CYCLES_DEF
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  load,
    input  logic [VALUE_W-1:0]    value,
    input  logic                  blank_en,
    input  logic [NUM_DIGITS-1:0] dp_mask,
    output logic                  busy,
    output scan_t                 scan_sig,
    output seg_t                  smg_data
);

    bcd_digits_t       digits;
    logic              digits_valid;
    scan_t             scan_pre;
    digit_idx_t        scan_idx;
    logic              frame_start;
    logic [BCD_W-1:0]  bcd;
    logic              blank;
    logic              dp;

    // Binary to BCD
    bin_to_bcd u_bin_to_bcd (
        .clk          (clk),
        .rst_n        (rst_n),
        .load         (load),
        .value        (value),
        .busy         (busy),
        .digits       (digits),
        .digits_valid (digits_valid)
    );

    // Digit timebase
    digit_scan #(
        .DIGIT_CYCLES (DIGIT_CYCLES)
    ) u_digit_scan (
        .clk          (clk),
        .rst_n        (rst_n),
        .scan_pre     (scan_pre),
        .scan_idx     (scan_idx),
        .frame_start  (frame_start)
    );

    digit_select u_digit_select (
        .clk          (clk),
        .rst_n        (rst_n),
        .digits       (digits),
        .digits_valid (digits_valid),
        .frame_start  (frame_start),
        .scan_idx     (scan_idx),
        .blank_en     (blank_en),
        .dp_mask      (dp_mask),
        .bcd          (bcd),
        .blank        (blank),
        .dp           (dp)
    );

    // Output stage
    seg_encode u_seg_encode (
        .clk          (clk),
        .rst_n        (rst_n),
        .bcd          (bcd),
        .blank        (blank),
        .dp           (dp),
        .scan_pre     (scan_pre),
        .smg_data     (smg_data),
        .scan_sig     (scan_sig)
    );

endmodule

// ==== test/tb_clock.sv ====
module tb_clock #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset released on a rising edge after a whole number of cycles
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== test/tb_smg_display.sv ====
module tb_smg_display
    import smg_pkg::*;
;

    localparam int DWELL        = 16;
    localparam int BUSY_CYCLES  = 20;
    localparam int FRAME_CYCLES = NUM_DIGITS * DWELL;
    localparam scan_t FIRST_SCAN = 6'b011111;

    // No digit selected and all segments dark
    localparam scan_t SCAN_IDLE = 6'b111111;
    localparam seg_t  SEG_IDLE  = 8'hff;

    // Room for 25 displayed values at about 4 frames each plus the scan test
    localparam int TEST_FRAMES    = 3 + 4 * 25;
    localparam int TIMEOUT_CYCLES = TEST_FRAMES * FRAME_CYCLES * 12 / 10;

    logic                  clk;
    logic                  rst_n;
    logic                  load;
    logic [VALUE_W-1:0]    value;
    logic                  blank_en;
    logic [NUM_DIGITS-1:0] dp_mask;
    logic                  busy;
    scan_t                 scan_sig;
    seg_t                  smg_data;

    // Expected display state is changed only while disarmed
    int unsigned           ref_value;
    logic                  ref_blank;
    logic [NUM_DIGITS-1:0] ref_mask;
    logic                  armed = 1'b0;

    scan_t  prev_scan;
    int     dwell;
    logic   frame_live;
    int     frames_seen = 0;
    int     frames_done = 0;
    int     seg_checks  = 0;
    int     err_count   = 0;
    int     test_errs   = 0;
    int     tests_run   = 0;
    int     tests_bad   = 0;
    integer seed;

    tb_clock #(.PERIOD(8), .RESET_CYCLES(5)) clock_i (.clk(clk), .rst_n(rst_n));

    smg_display #(.DIGIT_CYCLES(DWELL)) dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (load),
        .value    (value),
        .blank_en (blank_en),
        .dp_mask  (dp_mask),
        .busy     (busy),
        .scan_sig (scan_sig),
        .smg_data (smg_data)
    );

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // Lit segments active high with bit 0 as segment a
    function automatic logic [6:0] lit_segments(input int unsigned digit);
        case (digit)
            0:       return 7'h3f;
            1:       return 7'h06;
            2:       return 7'h5b;
            3:       return 7'h4f;
            4:       return 7'h66;
            5:       return 7'h6d;
            6:       return 7'h7d;
            7:       return 7'h07;
            8:       return 7'h7f;
            default: return 7'h6f;
        endcase
    endfunction

    // pos is the scan bit where 5 is the leftmost digit
    function automatic seg_t expect_seg(input int unsigned val, input logic blank_on,
                                        input logic [NUM_DIGITS-1:0] mask, input int pos);
        int unsigned shown_val;
        int unsigned weight;
        logic [6:0]  lit;
        shown_val = (val > VALUE_MAX) ? VALUE_MAX : val;
        weight = 1;
        for (int i = 0; i < pos; i++)
            weight = weight * 10;
        // Blank when this digit and all to its left are zero
        if (blank_on && pos != 0 && shown_val < weight)
            lit = '0;
        else
            lit = lit_segments((shown_val / weight) % 10);
        return {~mask[pos], ~lit};
    endfunction

    function automatic scan_t next_scan(input scan_t prev);
        if (prev == SCAN_IDLE)
            return FIRST_SCAN;
        return {prev[0], prev[NUM_DIGITS-1:1]};
    endfunction

    function automatic int lit_position(input scan_t s);
        int pos;
        pos = -1;
        for (int i = 0; i < NUM_DIGITS; i++)
            if (!s[i])
                pos = i;
        return pos;
    endfunction

    task automatic check_seg(input seg_t got, input seg_t exp, input string where);
        if (got !== exp) begin
            $display("mismatch smg_data %s: got %h expected %h", where, got, exp);
            err_count++;
        end
    endtask

    task automatic check_scan(input scan_t got, input scan_t exp);
        if (got !== exp) begin
            $display("mismatch scan_sig: got %h expected %h", got, exp);
            err_count++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Scan and segment monitor
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin : monitor
        scan_t s;
        int    pos;
        s = scan_sig;
        if (!rst_n) begin
            prev_scan  = SCAN_IDLE;
            dwell      = 0;
            frame_live = 1'b0;
        end else if (s != prev_scan) begin
            if (prev_scan != SCAN_IDLE && dwell != DWELL) begin
                $display("ERROR: select %h was held %0d cycles", prev_scan, dwell);
                err_count++;
            end
            check_scan(s, next_scan(prev_scan));
            // Only frames that start after arming are compared
            if (s == FIRST_SCAN) begin
                frames_seen <= frames_seen + 1;
                frame_live = armed;
            end
            prev_scan = s;
            dwell     = 1;
        end else begin
            dwell++;
            if (dwell == DWELL + 1) begin
                $display("ERROR: scan_sig stuck at %h too long", s);
                err_count++;
            end
            pos = lit_position(s);
            // Middle of the lit window
            if (dwell == DWELL / 2 && pos >= 0 && frame_live && armed) begin
                check_seg(smg_data, expect_seg(ref_value, ref_blank, ref_mask, pos),
                          $sformatf("digit %0d", pos));
                seg_checks++;
                if (pos == 0)
                    frames_done <= frames_done + 1;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("ERROR: timeout after %0d cycles, tests did not complete", cycles);
        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_bad,
                 err_count);
        $display("** FAIL **");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic setup_display(input int unsigned v, input logic b,
                                 input logic [NUM_DIGITS-1:0] m);
        @(posedge clk);
        armed     <= 1'b0;
        blank_en  <= b;
        dp_mask   <= m;
        ref_value <= v;
        ref_blank <= b;
        ref_mask  <= m;
    endtask

    task automatic pulse_load(input int unsigned v);
        @(posedge clk);
        value <= VALUE_W'(v);
        load  <= 1'b1;
        @(posedge clk);
        load  <= 1'b0;
    endtask

    task automatic measure_busy();
        int high;
        high = 0;
        @(posedge clk);
        while (busy) begin
            high++;
            @(posedge clk);
        end
        if (high != BUSY_CYCLES) begin
            $display("mismatch busy cycles: got %h expected %h", high, BUSY_CYCLES);
            err_count++;
        end
    endtask

    // Compare n whole frames against the reference
    task automatic show_frames(input int n);
        int target;
        @(posedge clk);
        armed <= 1'b1;
        target = frames_done + n;
        while (frames_done < target)
            @(posedge clk);
        armed <= 1'b0;
    endtask

    task automatic show_value(input int unsigned v, input logic b,
                              input logic [NUM_DIGITS-1:0] m);
        setup_display(v, b, m);
        pulse_load(v);
        measure_busy();
        show_frames(2);
    endtask

    task automatic end_test(input string name);
        int errs;
        @(negedge clk);
        errs = err_count - test_errs;
        test_errs = err_count;
        tests_run++;
        if (errs != 0)
            tests_bad++;
        $display("test %0d %s: %s (%0d errors)", tests_run, name,
                 (errs == 0) ? "ok" : "bad", errs);
    endtask

    initial begin : stimulus
        logic [31:0] rnd;
        int unsigned v;
        logic [NUM_DIGITS-1:0] m;
        load     = 1'b0;
        value    = '0;
        blank_en = 1'b0;
        dp_mask  = '0;
        seed     = 32'h8c3d;

        // Outputs idle in and right after reset
        repeat (2) @(posedge clk);
        check_scan(scan_sig, SCAN_IDLE);
        check_seg(smg_data, SEG_IDLE, "in reset");
        while (!rst_n)
            @(posedge clk);
        check_scan(scan_sig, SCAN_IDLE);
        check_seg(smg_data, SEG_IDLE, "after reset");
        while (frames_seen < 3)
            @(posedge clk);
        end_test("reset and scan order");

        show_value(0, 1'b0, '0);
        show_value(7, 1'b0, '0);
        show_value(123456, 1'b0, '0);
        show_value(999999, 1'b0, '0);
        end_test("conversion and display");

        show_value(20'hfffff, 1'b0, '0);
        // Second load lands while the first conversion runs
        setup_display(314159, 1'b0, '0);
        pulse_load(314159);
        repeat (2) @(posedge clk);
        value <= VALUE_W'(271828);
        load  <= 1'b1;
        @(posedge clk);
        load  <= 1'b0;
        while (busy)
            @(posedge clk);
        @(posedge clk);
        if (busy) begin
            $display("ERROR: busy rose again after a load given while busy");
            err_count++;
        end
        show_frames(2);
        end_test("clamp and dropped load");

        show_value(42, 1'b1, '0);
        show_value(0, 1'b1, '0);
        show_value(100200, 1'b1, '0);
        end_test("leading-zero blanking");

        show_value(5, 1'b1, 6'b100001);
        repeat (3) begin
            rnd = $random(seed);
            v = rnd % 1000;
            rnd = $random(seed);
            show_value(v, 1'b1, rnd[NUM_DIGITS-1:0]);
        end
        end_test("decimal points");

        repeat (12) begin
            rnd = $random(seed);
            v = rnd % 1048576;
            rnd = $random(seed);
            // Shift down now and then for leading zeros
            v = v >> (rnd % 20);
            m = rnd[NUM_DIGITS+7:8];
            show_value(v, rnd[31], m);
        end
        end_test("random values");

        if (seg_checks == 0) begin
            $display("ERROR: no segment samples were compared");
            err_count++;
        end
        $display("summary: %0d tests, %0d failed, %0d segment checks, %0d errors",
                 tests_run, tests_bad, seg_checks, err_count);
        if (err_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
common/smg_pkg.sv
src/bin_to_bcd.sv
smg/digit_scan.sv
smg/digit_select.sv
smg/seg_encode.sv
src/smg_display.sv
test/tb_clock.sv
test/tb_smg_display.sv

// ==== Makefile ====
TOP := tb_smg_display

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f tb.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -qF '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log
